/* logic/visualizerPkg.sv */
package visualizerPkg;

	// audio path
	localparam int sampleWidth = 16;
	localparam int powerWidth = 16;
	localparam int indexWidth = 8;

	// pixel coordinates
	localparam int xWidth = 10;
	localparam int yWidth = 9;

	// configuration bus
	localparam int wbAddrWidth = 4;
	localparam int wbDataWidth = 32;
	localparam int decayWidth = 4;

	// register map, address 3 is unmapped
	typedef enum logic [wbAddrWidth-1:0] {
		regEnable     = 4'd0,
		regBackground = 4'd1,
		regDecay      = 4'd2,
		regColor0     = 4'd4,
		regColor1     = 4'd5,
		regColor2     = 4'd6,
		regColor3     = 4'd7
	} regAddrT;

	// 24-bit pixel colour, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbT;

endpackage

/* logic/bandIfs.sv */
`timescale 1ns/1ps

// mono samples fanned out to every band meter
interface sampleBus #(
	parameter int NumBands = 4
);
	import visualizerPkg::*;

	logic sampleValid;
	logic signed [sampleWidth-1:0] sampleMono;
	logic [indexWidth-1:0] sampleIndex;
	logic [NumBands-1:0] bandEnable;

	modport source (output sampleValid, sampleMono, sampleIndex, bandEnable);
	modport listener (input sampleValid, sampleMono, sampleIndex, bandEnable);
endinterface

// one drawing layer per band
interface layerBus;
	import visualizerPkg::*;

	logic pixelValid;
	logic lit;
	rgbT color;
	// pixel position travels with the layer
	logic [xWidth-1:0] x;
	logic [yWidth-1:0] y;

	modport source (output pixelValid, lit, color, x, y);
	modport sink (input pixelValid, lit, color, x, y);
endinterface

/* logic/wbConfigRegs.sv */
`timescale 1ns/1ps

module wbConfigRegs #(
	parameter int NumBands = 4
) (
	input  logic clk,
	input  logic rstN,
	input  logic wbCyc,
	input  logic wbStb,
	input  logic wbWe,
	input  logic [visualizerPkg::wbAddrWidth-1:0] wbAdr,
	input  logic [visualizerPkg::wbDataWidth-1:0] wbDatWr,
	output logic [visualizerPkg::wbDataWidth-1:0] wbDatRd,
	output logic wbAck,
	output logic [NumBands-1:0] bandEnable,
	output logic [visualizerPkg::decayWidth-1:0] decayShift,
	output visualizerPkg::rgbT background,
	output visualizerPkg::rgbT bandColor [NumBands]
);
	import visualizerPkg::*;

	regAddrT addr;
	logic request;
	logic [1:0] colorSel;
	logic colorHit;
	logic [wbDataWidth-1:0] readData;

	// a request is served once, the ack cycle blocks a repeat
	assign request = wbCyc && wbStb && !wbAck;
	assign addr = regAddrT'(wbAdr);

	// colour registers sit at 4..7, only the low bits pick the band
	assign colorSel = wbAdr[1:0];
	assign colorHit = int'(colorSel) < NumBands;

	always_comb begin
		readData = '0;
		case (addr)
			regEnable: begin
				readData[NumBands-1:0] = bandEnable;
			end
			regBackground: begin
				readData[$bits(rgbT)-1:0] = background;
			end
			regDecay: begin
				readData[decayWidth-1:0] = decayShift;
			end
			regColor0, regColor1, regColor2, regColor3: begin
				if (colorHit) begin
					readData[$bits(rgbT)-1:0] = bandColor[colorSel];
				end
			end
			default: begin
				readData = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wbAck <= 1'b0;
			bandEnable <= '0;
			decayShift <= '0;
			background <= '0;
			for (int i = 0; i < NumBands; i++) begin
				bandColor[i] <= '0;
			end
		end else begin
			wbAck <= request;
			// write lands on the same edge that raises the ack
			if (request && wbWe) begin
				case (addr)
					regEnable: begin
						bandEnable <= wbDatWr[NumBands-1:0];
					end
					regBackground: begin
						background <= rgbT'(wbDatWr[$bits(rgbT)-1:0]);
					end
					regDecay: begin
						decayShift <= wbDatWr[decayWidth-1:0];
					end
					regColor0, regColor1, regColor2, regColor3: begin
						if (colorHit) begin
							bandColor[colorSel] <= rgbT'(wbDatWr[$bits(rgbT)-1:0]);
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// read data is captured with the request, shown during the ack
	always_ff @(posedge clk) begin
		if (request) begin
			wbDatRd <= readData;
		end
	end

	ackSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
		wbAck |=> !wbAck);

endmodule

/* logic/audioFrontEnd.sv */
`timescale 1ns/1ps

module audioFrontEnd #(
	parameter int NumBands = 4
) (
	input  logic clk,
	input  logic rstN,
	input  logic audioValid,
	input  logic signed [visualizerPkg::sampleWidth-1:0] audioL,
	input  logic signed [visualizerPkg::sampleWidth-1:0] audioR,
	input  logic [NumBands-1:0] bandEnable,
	sampleBus.source samples
);
	import visualizerPkg::*;

	logic signed [sampleWidth:0] stereoSum;
	logic started;

	// one extra bit so the sum never wraps
	assign stereoSum = audioL + audioR;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			samples.sampleValid <= 1'b0;
			samples.sampleIndex <= '0;
			samples.bandEnable <= '0;
			started <= 1'b0;
		end else begin
			samples.sampleValid <= audioValid;
			samples.bandEnable <= bandEnable;
			if (audioValid) begin
				started <= 1'b1;
				// first sample carries index 0, count saturates after that
				if (started && samples.sampleIndex != '1) begin
					samples.sampleIndex <= samples.sampleIndex + 1'b1;
				end
			end
		end
	end

	// mono mix, dropping bit 0 is the arithmetic shift by one
	always_ff @(posedge clk) begin
		if (audioValid) begin
			samples.sampleMono <= stereoSum[sampleWidth:1];
		end
	end

endmodule

/* logic/bandMeter.sv */
`timescale 1ns/1ps

module bandMeter #(
	parameter int BandIndex = 0,
	parameter int BarLeft = 16,
	parameter int BarPitch = 24,
	parameter int BarWidth = 32,
	parameter int BarBottom = 400,
	parameter int HeightShift = 7
) (
	input  logic clk,
	input  logic rstN,
	sampleBus.listener samples,
	input  logic [visualizerPkg::decayWidth-1:0] decayShift,
	input  visualizerPkg::rgbT color,
	input  logic pixelValid,
	input  logic [visualizerPkg::xWidth-1:0] pixelX,
	input  logic [visualizerPkg::yWidth-1:0] pixelY,
	layerBus.source layer
);
	import visualizerPkg::*;

	localparam int FastShift = BandIndex + 1;
	localparam int SlowShift = BandIndex + 3;
	localparam int BarX = BarLeft + BandIndex * BarPitch;

	logic enabled;
	logic filterStep;
	logic bandValid;
	logic signed [sampleWidth-1:0] fastState;
	logic signed [sampleWidth-1:0] slowState;
	logic signed [sampleWidth:0] fastDiff;
	logic signed [sampleWidth:0] slowDiff;
	logic signed [sampleWidth:0] fastNext;
	logic signed [sampleWidth:0] slowNext;
	logic signed [sampleWidth:0] bandOut;
	logic signed [sampleWidth:0] bandAbs;
	logic [powerWidth-1:0] magnitude;
	logic [powerWidth-1:0] power;
	logic [powerWidth-1:0] decayStep;
	logic [powerWidth-1:0] height;
	logic inColumn;
	logic inRows;

	assign enabled = samples.bandEnable[BandIndex];
	// the very first sample would only kick the filters into a transient
	assign filterStep = samples.sampleValid && enabled && (samples.sampleIndex != '0);

	// two one-pole low-pass stages, the band is their difference
	assign fastDiff = samples.sampleMono - fastState;
	assign slowDiff = samples.sampleMono - slowState;
	assign fastNext = fastState + (fastDiff >>> FastShift);
	assign slowNext = slowState + (slowDiff >>> SlowShift);
	assign bandOut = fastState - slowState;
	assign bandAbs = (bandOut < 0) ? -bandOut : bandOut;
	assign magnitude = bandAbs[powerWidth-1:0];

	// decay by a fraction of power, never stalling above zero
	always_comb begin
		decayStep = power >> decayShift;
		if (decayStep == '0 && power != '0) begin
			decayStep = 1;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fastState <= '0;
			slowState <= '0;
			bandValid <= 1'b0;
			power <= '0;
		end else if (!enabled) begin
			fastState <= '0;
			slowState <= '0;
			bandValid <= 1'b0;
			power <= '0;
		end else begin
			bandValid <= filterStep;
			if (filterStep) begin
				fastState <= fastNext[sampleWidth-1:0];
				slowState <= slowNext[sampleWidth-1:0];
			end
			// envelope follows one cycle behind the filters
			if (bandValid) begin
				if (magnitude > power) begin
					power <= magnitude;
				end else begin
					power <= power - decayStep;
				end
			end
		end
	end

	// bar rises from BarBottom, rows (BarBottom - height, BarBottom]
	assign height = power >> HeightShift;
	assign inColumn = (int'(pixelX) >= BarX) && (int'(pixelX) < BarX + BarWidth);
	assign inRows = (int'(pixelY) <= BarBottom) && (int'(pixelY) + int'(height) > BarBottom);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			layer.pixelValid <= 1'b0;
			layer.lit <= 1'b0;
		end else begin
			layer.pixelValid <= pixelValid;
			layer.lit <= pixelValid && enabled && inColumn && inRows;
		end
	end

	always_ff @(posedge clk) begin
		layer.color <= color;
		layer.x <= pixelX;
		layer.y <= pixelY;
	end

	litNeedsPixel: assert property (@(posedge clk) disable iff (!rstN)
		layer.lit |-> layer.pixelValid);

endmodule

/* logic/layerCompositor.sv */
`timescale 1ns/1ps

module layerCompositor #(
	parameter int NumBands = 4
) (
	input  logic clk,
	input  logic rstN,
	layerBus.sink layers [NumBands],
	input  visualizerPkg::rgbT background,
	output logic rgbValid,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);
	import visualizerPkg::*;

	logic [NumBands-1:0] litVec;
	logic [NumBands-1:0] validVec;
	logic [NumBands-1:0] topLayer;
	logic higherLit;
	rgbT layerColor [NumBands];
	logic [xWidth-1:0] layerX [NumBands];
	logic [yWidth-1:0] layerY [NumBands];
	rgbT pick;

	for (genvar i = 0; i < NumBands; i++) begin : gather
		assign litVec[i] = layers[i].lit;
		assign validVec[i] = layers[i].pixelValid;
		assign layerColor[i] = layers[i].color;
		assign layerX[i] = layers[i].x;
		assign layerY[i] = layers[i].y;

		// every meter must be working on the same pixel
		layersAligned: assert property (@(posedge clk) disable iff (!rstN)
			validVec[i] == validVec[0] &&
			(!validVec[0] || (layerX[i] == layerX[0] && layerY[i] == layerY[0])));
	end

	// keep only the most significant lit layer
	always_comb begin
		higherLit = 1'b0;
		for (int i = NumBands - 1; i >= 0; i--) begin
			topLayer[i] = litVec[i] && !higherLit;
			higherLit = higherLit | litVec[i];
		end
	end

	// topLayer is one-hot or empty
	always_comb begin
		pick = background;
		for (int i = 0; i < NumBands; i++) begin
			if (topLayer[i]) begin
				pick = layerColor[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rgbValid <= 1'b0;
		end else begin
			rgbValid <= validVec[0];
		end
	end

	always_ff @(posedge clk) begin
		red <= pick.red;
		green <= pick.green;
		blue <= pick.blue;
	end

endmodule

/* logic/spectrumDisplay.sv */
`timescale 1ns/1ps

module spectrumDisplay #(
	parameter int NumBands = 4,
	parameter int BarLeft = 16,
	parameter int BarPitch = 24,
	parameter int BarWidth = 32,
	parameter int BarBottom = 400,
	parameter int HeightShift = 7
) (
	input  logic clk,
	input  logic rstN,
	input  logic wbCyc,
	input  logic wbStb,
	input  logic wbWe,
	input  logic [visualizerPkg::wbAddrWidth-1:0] wbAdr,
	input  logic [visualizerPkg::wbDataWidth-1:0] wbDatWr,
	output logic [visualizerPkg::wbDataWidth-1:0] wbDatRd,
	output logic wbAck,
	input  logic audioValid,
	input  logic signed [visualizerPkg::sampleWidth-1:0] audioL,
	input  logic signed [visualizerPkg::sampleWidth-1:0] audioR,
	input  logic pixelValid,
	input  logic [visualizerPkg::xWidth-1:0] pixelX,
	input  logic [visualizerPkg::yWidth-1:0] pixelY,
	output logic rgbValid,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);
	import visualizerPkg::*;

	logic [NumBands-1:0] bandEnable;
	logic [decayWidth-1:0] decayShift;
	rgbT background;
	rgbT bandColor [NumBands];

	sampleBus #(.NumBands(NumBands)) samples ();
	layerBus layers [NumBands] ();

	wbConfigRegs #(.NumBands(NumBands)) configRegs (
		.clk(clk),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatWr(wbDatWr),
		.wbDatRd(wbDatRd),
		.wbAck(wbAck),
		.bandEnable(bandEnable),
		.decayShift(decayShift),
		.background(background),
		.bandColor(bandColor)
	);

	audioFrontEnd #(.NumBands(NumBands)) frontEnd (
		.clk(clk),
		.rstN(rstN),
		.audioValid(audioValid),
		.audioL(audioL),
		.audioR(audioR),
		.bandEnable(bandEnable),
		.samples(samples)
	);

	// band 0 is the widest band and the leftmost bar
	for (genvar i = 0; i < NumBands; i++) begin : bands
		bandMeter #(
			.BandIndex(i),
			.BarLeft(BarLeft),
			.BarPitch(BarPitch),
			.BarWidth(BarWidth),
			.BarBottom(BarBottom),
			.HeightShift(HeightShift)
		) meter (
			.clk(clk),
			.rstN(rstN),
			.samples(samples),
			.decayShift(decayShift),
			.color(bandColor[i]),
			.pixelValid(pixelValid),
			.pixelX(pixelX),
			.pixelY(pixelY),
			.layer(layers[i])
		);
	end

	layerCompositor #(.NumBands(NumBands)) compositor (
		.clk(clk),
		.rstN(rstN),
		.layers(layers),
		.background(background),
		.rgbValid(rgbValid),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

/* tests/displayChecker.sv */
`timescale 1ns/1ps

module displayChecker #(
	parameter int NumBands = 4,
	parameter int BarLeft = 16,
	parameter int BarPitch = 24,
	parameter int BarWidth = 32,
	parameter int BarBottom = 400,
	parameter int HeightShift = 7
) (
	input logic clk,
	input logic rstN,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [visualizerPkg::wbAddrWidth-1:0] wbAdr,
	input logic [visualizerPkg::wbDataWidth-1:0] wbDatWr,
	input logic [visualizerPkg::wbDataWidth-1:0] wbDatRd,
	input logic wbAck,
	input logic audioValid,
	input logic signed [visualizerPkg::sampleWidth-1:0] audioL,
	input logic signed [visualizerPkg::sampleWidth-1:0] audioR,
	input logic pixelValid,
	input logic [visualizerPkg::xWidth-1:0] pixelX,
	input logic [visualizerPkg::yWidth-1:0] pixelY,
	input logic rgbValid,
	input logic [7:0] red,
	input logic [7:0] green,
	input logic [7:0] blue
);
	int errorCount;
	// model registers
	logic [NumBands-1:0] enable;
	logic [NumBands-1:0] enCopy;
	logic [3:0] decay;
	logic [23:0] background;
	logic [23:0] color [NumBands];
	logic ackExp;
	logic request;
	logic readExpected;
	logic [31:0] readValue;
	// audio and envelope state
	logic monoValid;
	logic started;
	int mono;
	int index;
	int fast [NumBands];
	int slow [NumBands];
	logic stepped [NumBands];
	int power [NumBands];
	// pixel pipeline
	logic valid1;
	logic [NumBands-1:0] lit1;
	logic [23:0] color1 [NumBands];
	logic validExp;
	logic [23:0] rgbExp;

	assign request = wbCyc && wbStb && !ackExp;

	function automatic logic [31:0] regValue(input logic [3:0] adr);
		logic [31:0] value;
		value = '0;
		case (adr)
			4'd0: value[NumBands-1:0] = enable;
			4'd1: value[23:0] = background;
			4'd2: value[3:0] = decay;
			default: begin
				if (adr[3:2] == 2'b01 && int'(adr[1:0]) < NumBands) value[23:0] = color[adr[1:0]];
			end
		endcase
		return value;
	endfunction

	// one-pole low-pass step, result wraps to the sample width
	function automatic int lowPass(input int state, input int sample, input int shift);
		logic signed [15:0] wrapped;
		wrapped = state + ((sample - state) >>> shift);
		return wrapped;
	endfunction

	// peak hold with proportional decay
	function automatic int envelope(input int level, input int band, input int shift);
		int mag;
		int step;
		mag = (band < 0) ? -band : band;
		mag = mag & 16'hFFFF;
		if (mag > level) return mag;
		step = level >> shift;
		if (step == 0 && level != 0) step = 1;
		return level - step;
	endfunction

	function automatic logic onBar(input int band, input int x, input int y, input int level);
		int left;
		int height;
		left = BarLeft + band * BarPitch;
		height = level >> HeightShift;
		return x >= left && x < left + BarWidth && y <= BarBottom && y > BarBottom - height;
	endfunction

	// the highest lit band overwrites everything below it
	function automatic logic [23:0] topColor();
		logic [23:0] value;
		value = background;
		for (int b = 0; b < NumBands; b++) begin
			if (lit1[b]) value = color1[b];
		end
		return value;
	endfunction

	task automatic expectEqual(input string name, input logic [31:0] expected,
			input logic [31:0] observed);
		if (observed !== expected) begin
			errorCount++;
			$display("FAIL %s: expected %h, observed %h", name, expected, observed);
		end
	endtask

	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			enable <= '0;
			enCopy <= '0;
			decay <= '0;
			background <= '0;
			ackExp <= 1'b0;
			readExpected <= 1'b0;
			monoValid <= 1'b0;
			started <= 1'b0;
			index <= 0;
			valid1 <= 1'b0;
			lit1 <= '0;
			validExp <= 1'b0;
			for (int b = 0; b < NumBands; b++) begin
				color[b] <= '0;
				fast[b] <= 0;
				slow[b] <= 0;
				stepped[b] <= 1'b0;
				power[b] <= 0;
			end
		end else begin
			// outputs launched by the previous edge
			expectEqual("wbAck", ackExp, wbAck);
			if (ackExp && readExpected) expectEqual("wbDatRd", readValue, wbDatRd);
			expectEqual("rgbValid", validExp, rgbValid);
			if (validExp) begin
				expectEqual("red", rgbExp[23:16], red);
				expectEqual("green", rgbExp[15:8], green);
				expectEqual("blue", rgbExp[7:0], blue);
			end

			ackExp <= request;
			if (request) begin
				readExpected <= !wbWe;
				readValue <= regValue(wbAdr);
			end
			if (request && wbWe) begin
				case (wbAdr)
					4'd0: enable <= wbDatWr[NumBands-1:0];
					4'd1: background <= wbDatWr[23:0];
					4'd2: decay <= wbDatWr[3:0];
					default: begin
						if (wbAdr[3:2] == 2'b01 && int'(wbAdr[1:0]) < NumBands) begin
							color[wbAdr[1:0]] <= wbDatWr[23:0];
						end
					end
				endcase
			end

			enCopy <= enable;
			monoValid <= audioValid;
			if (audioValid) begin
				mono <= (int'(audioL) + int'(audioR)) >>> 1;
				started <= 1'b1;
				if (started && index < 255) index <= index + 1;
			end

			valid1 <= pixelValid;
			validExp <= valid1;
			rgbExp <= topColor();
			for (int b = 0; b < NumBands; b++) begin
				lit1[b] <= pixelValid && enCopy[b] && onBar(b, pixelX, pixelY, power[b]);
				color1[b] <= color[b];
				if (!enCopy[b]) begin
					fast[b] <= 0;
					slow[b] <= 0;
					stepped[b] <= 1'b0;
					power[b] <= 0;
				end else begin
					// the first sample after reset is skipped
					stepped[b] <= monoValid && index != 0;
					if (monoValid && index != 0) begin
						fast[b] <= lowPass(fast[b], mono, b + 1);
						slow[b] <= lowPass(slow[b], mono, b + 3);
					end
					if (stepped[b]) power[b] <= envelope(power[b], fast[b] - slow[b], decay);
				end
			end
		end
	end

endmodule

/* tests/spectrumDisplayTb.sv */
`timescale 1ns/1ps

module spectrumDisplayTb;
	typedef enum logic [1:0] {silence, constant, alternate, noise} patternT;

	typedef struct packed {
		patternT pattern;
		logic [15:0] amplitude;
		logic [15:0] sampleCount;
		logic [3:0][9:0] probeX;
	} rowT;

	// register writes attached to a table row, with the expected readback
	typedef struct packed {
		logic [7:0] row;
		logic [3:0] adr;
		logic [31:0] dat;
		logic [31:0] readBack;
	} writeT;

	localparam int NumBands = 4;
	localparam int BarBottom = 400;
	localparam int HeightShift = 7;
	localparam int NumRows = 9;
	localparam int NumWrites = 13;
	localparam int WaitLimit = 100;

	logic clk = 1'b0;
	logic rstN;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [3:0] wbAdr;
	logic [31:0] wbDatWr;
	logic [31:0] wbDatRd;
	logic wbAck;
	logic audioValid;
	logic signed [15:0] audioL;
	logic signed [15:0] audioR;
	logic pixelValid;
	logic [9:0] pixelX;
	logic [8:0] pixelY;
	logic rgbValid;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	int tbErrors;
	int timeouts;
	rowT rows [NumRows];
	writeT writes [NumWrites];

	spectrumDisplay #(
		.NumBands(NumBands),
		.BarBottom(BarBottom),
		.HeightShift(HeightShift)
	) i_spectrumDisplay (.*);

	displayChecker #(
		.NumBands(NumBands),
		.BarBottom(BarBottom),
		.HeightShift(HeightShift)
	) scoreboard (.*);

	always #4 clk = ~clk;

	initial begin
		writes[0] = {8'd0, 4'd4, 32'h00FF0000, 32'h00FF0000};
		writes[1] = {8'd0, 4'd5, 32'h0000FF00, 32'h0000FF00};
		writes[2] = {8'd0, 4'd6, 32'h000000FF, 32'h000000FF};
		writes[3] = {8'd0, 4'd7, 32'h00FFFF00, 32'h00FFFF00};
		writes[4] = {8'd0, 4'd1, 32'h00102030, 32'h00102030};
		writes[5] = {8'd0, 4'd2, 32'h00000003, 32'h00000003};
		writes[6] = {8'd0, 4'd3, 32'hDEADBEEF, 32'h00000000};
		writes[7] = {8'd1, 4'd0, 32'hFFFFFFFF, 32'h0000000F};
		writes[8] = {8'd4, 4'd0, 32'h0000000B, 32'h0000000B};
		writes[9] = {8'd5, 4'd0, 32'h0000000F, 32'h0000000F};
		writes[10] = {8'd6, 4'd2, 32'h00000001, 32'h00000001};
		writes[11] = {8'd7, 4'd2, 32'h00000036, 32'h00000006};
		writes[12] = {8'd7, 4'd1, 32'hFF808080, 32'h00808080};
		// pattern, amplitude, samples, four probe columns
		rows[0] = {silence, 16'd0, 16'd0, 10'd20, 10'd44, 10'd68, 10'd92};
		rows[1] = {silence, 16'd0, 16'd40, 10'd16, 10'd47, 10'd71, 10'd119};
		rows[2] = {alternate, 16'd12000, 16'd200, 10'd30, 10'd42, 10'd66, 10'd90};
		rows[3] = {noise, 16'd0, 16'd300, 10'd40, 10'd47, 10'd64, 10'd95};
		rows[4] = {constant, 16'd8000, 16'd4, 10'd8, 10'd70, 10'd80, 10'd120};
		rows[5] = {silence, 16'd0, 16'd60, 10'd44, 10'd68, 10'd80, 10'd92};
		rows[6] = {silence, 16'd0, 16'd40, 10'd20, 10'd46, 10'd70, 10'd94};
		rows[7] = {alternate, 16'd20000, 16'd150, 10'd24, 10'd45, 10'd69, 10'd93};
		rows[8] = {silence, 16'd0, 16'd60, 10'd24, 10'd45, 10'd69, 10'd93};
	end

	task automatic wbTransfer(input logic [3:0] adr, input logic [31:0] dat, input logic we,
			output logic [31:0] data);
		int cycles;
		cycles = 0;
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatWr = dat;
		do begin
			@(negedge clk);
			cycles++;
		end while (!wbAck && cycles < WaitLimit);
		if (!wbAck) begin
			timeouts++;
			$display("Timeout: no Wishbone acknowledge for address %0d.", adr);
		end
		data = wbDatRd;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic readCheck(input logic [3:0] adr, input logic [31:0] expected);
		logic [31:0] data;
		wbTransfer(adr, '0, 1'b0, data);
		if (data !== expected) begin
			tbErrors++;
			$display("FAIL wbDatRd: address %h expected %h, observed %h", adr, expected, data);
		end
	endtask

	// one sample every other cycle
	task automatic driveSamples(input rowT row);
		logic signed [15:0] left;
		logic signed [15:0] right;
		for (int i = 0; i < row.sampleCount; i++) begin
			case (row.pattern)
				silence: left = '0;
				constant: left = $signed(row.amplitude);
				alternate: left = (i % 2) ? -$signed(row.amplitude) : $signed(row.amplitude);
				default: left = $urandom;
			endcase
			right = (row.pattern == noise) ? 16'($urandom) : left;
			@(negedge clk);
			audioValid = 1'b1;
			audioL = left;
			audioR = right;
			@(negedge clk);
			audioValid = 1'b0;
		end
	endtask

	// stream a column of pixels, then wait for the results to drain
	task automatic probeColumn(input int x);
		int ys [$];
		int top;
		int cycles;
		for (int y = BarBottom + 4; y >= 128; y -= 4) ys.push_back(y);
		// rows just above and at the top of each bar
		for (int b = 0; b < NumBands; b++) begin
			top = BarBottom - (scoreboard.power[b] >> HeightShift);
			if (top >= 0 && top < 511) begin
				ys.push_back(top);
				ys.push_back(top + 1);
			end
		end
		foreach (ys[i]) begin
			@(negedge clk);
			pixelValid = 1'b1;
			pixelX = x;
			pixelY = ys[i];
		end
		@(negedge clk);
		pixelValid = 1'b0;
		cycles = 0;
		while (rgbValid && cycles < WaitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (rgbValid) begin
			timeouts++;
			$display("Timeout: rgbValid did not drop after the pixel burst at x %0d.", x);
		end
	endtask

	initial begin
		logic [31:0] data;
		void'($urandom(53440));
		tbErrors = 0;
		timeouts = 0;
		rstN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatWr = '0;
		audioValid = 1'b0;
		audioL = '0;
		audioR = '0;
		pixelValid = 1'b0;
		pixelX = '0;
		pixelY = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// every address reads zero out of reset
		for (int a = 0; a < 16; a++) begin
			readCheck(a, 32'h0);
		end

		foreach (rows[r]) begin
			foreach (writes[w]) begin
				if (writes[w].row == r) begin
					wbTransfer(writes[w].adr, writes[w].dat, 1'b1, data);
					readCheck(writes[w].adr, writes[w].readBack);
				end
			end
			driveSamples(rows[r]);
			// last sample reaches the envelope three edges later
			repeat (3) @(negedge clk);
			for (int k = 3; k >= 0; k--) begin
				probeColumn(rows[r].probeX[k]);
			end
		end

		$display("Error counts: checker %0d, readback %0d, timeouts %0d",
			scoreboard.errorCount, tbErrors, timeouts);
		if (scoreboard.errorCount == 0 && tbErrors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
logic/visualizerPkg.sv
logic/bandIfs.sv
logic/wbConfigRegs.sv
logic/audioFrontEnd.sv
logic/bandMeter.sv
logic/layerCompositor.sv
logic/spectrumDisplay.sv
tests/displayChecker.sv
tests/spectrumDisplayTb.sv
